//--- Makefile
TOP := rv_core_tb

.PHONY: sim clean

# Build and run the testbench, a $fatal in the run gives a failing exit status
sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f rv_core.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- include/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Integer datapath width
`define XLEN 64

// Architectural integer registers
`define NUM_REGS 32

// Register index width, log2 of NUM_REGS
`define REG_ADDR_W 5

`endif

//--- rv_core.f
+incdir+include
src/rv_core_pkg.sv
src/rv_stage_if.sv
src/regfile64.sv
src/operand_stage.sv
src/execute_stage.sv
src/rv_core.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

//--- src/execute_stage.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module execute_stage (
    input  logic clock,
    input  logic reset_n,
    id_ex_if.dst id_ex,
    ex_wb_if.src ex_wb
);
    import rv_core_pkg::*;

    logic             fwd_ok;
    logic             fwd_a;
    logic             fwd_b;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    // Previous instruction's result is still sitting in the output register
    assign fwd_ok = ex_wb.rd_write && (ex_wb.rd != '0);
    assign fwd_a  = fwd_ok && (ex_wb.rd == id_ex.rs1);
    assign fwd_b  = fwd_ok && id_ex.uses_rs2 && (ex_wb.rd == id_ex.rs2);

    assign op_a = fwd_a ? ex_wb.result : id_ex.op_a;
    assign op_b = fwd_b ? ex_wb.result : id_ex.op_b;

    assign shamt = op_b[5:0];  // RV64 shift amount

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLL: alu_result = op_a << shamt;
            ALU_SRL: alu_result = op_a >> shamt;  // Logical
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ex_wb.valid    <= 1'b0;
            ex_wb.rd_write <= 1'b0;
        end else begin
            ex_wb.valid    <= id_ex.valid;
            ex_wb.rd_write <= id_ex.valid && !id_ex.illegal;
        end
    end

    always_ff @(posedge clock) begin
        if (id_ex.valid) begin
            ex_wb.illegal <= id_ex.illegal;
            ex_wb.rd      <= id_ex.rd;
            // Illegal words retire with zero data
            ex_wb.result  <= id_ex.illegal ? '0 : alu_result;
        end
    end

endmodule

//--- src/operand_stage.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module operand_stage (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     instr_valid,
    input  rv_core_pkg::instr_word_t instr,
    output logic [`REG_ADDR_W-1:0]   rs1,
    output logic [`REG_ADDR_W-1:0]   rs2,
    input  logic [`XLEN-1:0]         rs1_read_data,
    input  logic [`XLEN-1:0]         rs2_read_data,
    id_ex_if.src                     id_ex
);
    import rv_core_pkg::*;

    alu_op_t          dec_op;
    logic             dec_uses_rs2;
    logic             dec_illegal;
    logic             f7_zero;
    logic [`XLEN-1:0] imm_sext;

    // Register read happens straight off the incoming word
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    assign f7_zero  = (instr.r.funct7 == 7'b0);
    assign imm_sext = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    always_comb begin
        dec_op       = ALU_ADD;
        dec_uses_rs2 = 1'b0;
        dec_illegal  = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                dec_uses_rs2 = 1'b1;
                case (instr.r.funct3)
                    F3_ADD: begin
                        if (instr.r.funct7 == F7_SUB) begin
                            dec_op = ALU_SUB;
                        end else begin
                            dec_illegal = !f7_zero;
                        end
                    end
                    F3_SLL: begin dec_op = ALU_SLL; dec_illegal = !f7_zero; end
                    F3_XOR: begin dec_op = ALU_XOR; dec_illegal = !f7_zero; end
                    F3_SRL: begin dec_op = ALU_SRL; dec_illegal = !f7_zero; end
                    F3_OR:  begin dec_op = ALU_OR;  dec_illegal = !f7_zero; end
                    F3_AND: begin dec_op = ALU_AND; dec_illegal = !f7_zero; end
                    default: dec_illegal = 1'b1;  // SLT, SLTU
                endcase
            end
            OPC_OP_IMM: begin
                case (instr.i.funct3)
                    F3_ADD: dec_op = ALU_ADD;
                    F3_XOR: dec_op = ALU_XOR;
                    F3_OR:  dec_op = ALU_OR;
                    F3_AND: dec_op = ALU_AND;
                    default: dec_illegal = 1'b1;  // Immediate shifts and compares not supported
                endcase
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= instr_valid;
        end
    end

    // Payload only loads on a valid slot
    always_ff @(posedge clock) begin
        if (instr_valid) begin
            id_ex.illegal  <= dec_illegal;
            id_ex.alu_op   <= dec_op;
            id_ex.rs1      <= instr.r.rs1;
            id_ex.rs2      <= instr.r.rs2;
            id_ex.rd       <= instr.r.rd;
            id_ex.uses_rs2 <= dec_uses_rs2;
            id_ex.op_a     <= rs1_read_data;
            id_ex.op_b     <= dec_uses_rs2 ? rs2_read_data : imm_sext;
        end
    end

endmodule

//--- src/regfile64.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module regfile64 (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1_read_data,
    output logic [`XLEN-1:0]       rs2_read_data,
    ex_wb_if.dst                   wb
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    logic wr_en;

    // One read port, write data bypasses the array on a hit
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        logic hit;
        hit = wr_en && (wb.rd == addr);
        if (hit) begin
            return wb.result;
        end
        return regs[addr];
    endfunction

    // x0 is never written, so it reads zero from the array
    assign wr_en = wb.rd_write && (wb.rd != '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rs1_read_data = read_port(rs1);
    end

    always_comb begin
        rs2_read_data = read_port(rs2);
    end

endmodule

//--- src/rv_core.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module rv_core (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     instr_valid,
    input  rv_core_pkg::instr_word_t instr,
    output logic                     retire_valid,
    output logic                     retire_illegal,
    output logic [`REG_ADDR_W-1:0]   retire_rd,
    output logic [`XLEN-1:0]         retire_data
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    // Stage 1, decode and register read
    operand_stage u_operand (
        .clock         (clock),
        .reset_n       (reset_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rs1           (rs1_addr),
        .rs2           (rs2_addr),
        .rs1_read_data (rs1_data),
        .rs2_read_data (rs2_data),
        .id_ex         (id_ex.src)
    );

    // Stage 2, forward and ALU
    execute_stage u_execute (
        .clock   (clock),
        .reset_n (reset_n),
        .id_ex   (id_ex.dst),
        .ex_wb   (ex_wb.src)
    );

    regfile64 u_regfile (
        .clock         (clock),
        .reset_n       (reset_n),
        .rs1           (rs1_addr),
        .rs2           (rs2_addr),
        .rs1_read_data (rs1_data),
        .rs2_read_data (rs2_data),
        .wb            (ex_wb.dst)
    );

    assign retire_valid   = ex_wb.valid;    // Same cycle as the register write
    assign retire_illegal = ex_wb.illegal;
    assign retire_rd      = ex_wb.rd;
    assign retire_data    = ex_wb.result;

endmodule

//--- src/rv_core_pkg.sv
package rv_core_pkg;

    // R-type layout, register to register ops
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    // I-type layout, bits 31:20 hold the immediate instead of funct7/rs2
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef union packed { r_format_t r; i_format_t i; } instr_word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;   // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Alternate funct7 selecting SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

//--- src/rv_stage_if.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

// Operand stage to execute stage
interface id_ex_if;
    import rv_core_pkg::*;

    logic                   valid;
    logic                   illegal;
    alu_op_t                alu_op;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;      // rs2 value or sign-extended immediate
    logic                   uses_rs2;  // op_b came from rs2, so it may be forwarded

    modport src (output valid, illegal, alu_op, rs1, rs2, rd, op_a, op_b, uses_rs2);
    modport dst (input  valid, illegal, alu_op, rs1, rs2, rd, op_a, op_b, uses_rs2);

endinterface

// Execute stage result, feeds register write and retire port
interface ex_wb_if;

    logic                   valid;
    logic                   illegal;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       result;
    logic                   rd_write;  // valid and not illegal

    modport src (output valid, illegal, rd, result, rd_write);
    modport dst (input  valid, illegal, rd, result, rd_write);

endinterface

//--- tb/rv_core_properties.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module rv_core_properties (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   instr_valid,
    input logic                   retire_valid,
    input logic                   retire_illegal,
    input logic [`REG_ADDR_W-1:0] retire_rd,
    input logic [`XLEN-1:0]       regs [`NUM_REGS]
);

    // Nothing retires while the core is held in reset
    reset_quiet: assert property (@(posedge clock) !reset_n |-> !retire_valid)
        else $error("retire_valid high while reset_n is low");

    // Register 0 never holds anything but zero
    x0_zero: assert property (@(posedge clock) regs[0] == '0)
        else $error("register x0 holds a nonzero value");

    // Fixed two-edge latency from issue to retire
    retire_latency: assert property (@(posedge clock) disable iff (!reset_n)
        retire_valid == $past(instr_valid, 2))
        else $error("retire_valid does not follow instr_valid by two cycles");

    // An illegal word leaves its destination register untouched
    write_gating: assert property (@(posedge clock) disable iff (!reset_n)
        retire_valid && retire_illegal |=>
            regs[$past(retire_rd)] == $past(regs[retire_rd]))
        else $error("register file written by an illegal instruction");

endmodule

bind rv_core rv_core_properties props0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .instr_valid    (instr_valid),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .regs           (u_regfile.regs)
);

//--- tb/rv_core_tb.sv
`timescale 1ns/100ps
`include "rv_core_params.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 8;
    // At most one idle cycle per instruction, plus reset and drain
    localparam int MAX_CYCLES   = 2 * NUM_INSTR + RESET_CYCLES + 200;

    logic                   clock;
    logic                   reset_n;
    logic                   instr_valid;
    instr_word_t            instr;
    logic                   retire_valid;
    logic                   retire_illegal;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;

    logic [31:0]            rng_state;
    logic [`XLEN-1:0]       model_regs [`NUM_REGS];
    logic [`REG_ADDR_W-1:0] exp_rd [$];
    logic [`XLEN-1:0]       exp_data [$];
    logic                   exp_illegal [$];
    int                     exp_due [$];   // Cycle in which the retire is expected
    int                     cycle_count;
    int                     watchdog_count = 0;

    rv_core dut0 (
        .clock          (clock),
        .reset_n        (reset_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_illegal (retire_illegal),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    always @(posedge clock) begin
        watchdog_count++;
        if (watchdog_count >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: run exceeded %0d cycles", MAX_CYCLES));
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Three in four picks land on x0..x3 to force dependencies
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_random();
        if (r[31:30] != 2'b00) begin
            return {3'b000, r[21:20]};
        end
        return r[20:16];
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        r = next_random();
        if (int'(r[31:16] % 16'd10) >= 8) begin
            return next_random();  // Raw word, mostly illegal
        end
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        r    = next_random();
        imm  = r[27:16];
        r    = next_random();
        kind = int'(r[31:16] % 16'd11);
        case (kind)
            0: w = {7'b0000000, rs2, rs1, F3_ADD, rd, OPC_OP};
            1: w = {F7_SUB,     rs2, rs1, F3_ADD, rd, OPC_OP};
            2: w = {7'b0000000, rs2, rs1, F3_AND, rd, OPC_OP};
            3: w = {7'b0000000, rs2, rs1, F3_OR,  rd, OPC_OP};
            4: w = {7'b0000000, rs2, rs1, F3_XOR, rd, OPC_OP};
            5: w = {7'b0000000, rs2, rs1, F3_SLL, rd, OPC_OP};
            6: w = {7'b0000000, rs2, rs1, F3_SRL, rd, OPC_OP};
            7: w = {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
            8: w = {imm, rs1, F3_AND, rd, OPC_OP_IMM};
            9: w = {imm, rs1, F3_OR,  rd, OPC_OP_IMM};
            default: w = {imm, rs1, F3_XOR, rd, OPC_OP_IMM};
        endcase
        return w;
    endfunction

    // Reference model, executes in program order at issue
    task automatic model_issue(input logic [31:0] w, input int due);
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [4:0]       rd;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] res;
        logic             ill;
        opc = w[6:0];
        rd  = w[11:7];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{(`XLEN-12){w[31]}}, w[31:20]};
        ill = 1'b0;
        res = '0;
        if (opc == OPC_OP) begin
            if (f3 == F3_ADD && f7 == F7_SUB) begin
                res = a - b;
            end else if (f7 != 7'b0000000) begin
                ill = 1'b1;
            end else begin
                case (f3)
                    F3_ADD:  res = a + b;
                    F3_SLL:  res = a << b[5:0];
                    F3_XOR:  res = a ^ b;
                    F3_SRL:  res = a >> b[5:0];
                    F3_OR:   res = a | b;
                    F3_AND:  res = a & b;
                    default: ill = 1'b1;
                endcase
            end
        end else if (opc == OPC_OP_IMM) begin
            case (f3)
                F3_ADD:  res = a + imm;
                F3_XOR:  res = a ^ imm;
                F3_OR:   res = a | imm;
                F3_AND:  res = a & imm;
                default: ill = 1'b1;
            endcase
        end else begin
            ill = 1'b1;
        end
        if (ill) begin
            res = '0;  // Illegal words retire with zero data
        end else if (rd != 5'd0) begin
            model_regs[rd] = res;
        end
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        exp_illegal.push_back(ill);
        exp_due.push_back(due);
    endtask

    task automatic check_retire_rd(input logic [`REG_ADDR_W-1:0] got,
                                   input logic [`REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED retire_rd: got 0x%0h expected 0x%0h (cycle %0d)",
                               got, exp, cycle_count));
        end
    endtask

    task automatic check_retire_data(input logic [`XLEN-1:0] got,
                                     input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED retire_data: got 0x%016h expected 0x%016h (cycle %0d)",
                               got, exp, cycle_count));
        end
    endtask

    task automatic check_retire_illegal(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED retire_illegal: got 0x%0h expected 0x%0h (cycle %0d)",
                               got, exp, cycle_count));
        end
    endtask

    // Sampled at the falling edge, half a cycle after the outputs settle
    task automatic check_retire_port();
        if (retire_valid === 1'b1) begin
            if (exp_due.size() == 0) begin
                fail_run($sformatf("Retire in cycle %0d with nothing in flight", cycle_count));
            end else if (exp_due[0] != cycle_count) begin
                fail_run($sformatf("Retire in cycle %0d, expected in cycle %0d",
                                   cycle_count, exp_due[0]));
            end else begin
                check_retire_rd(retire_rd, exp_rd.pop_front());
                check_retire_data(retire_data, exp_data.pop_front());
                check_retire_illegal(retire_illegal, exp_illegal.pop_front());
                void'(exp_due.pop_front());
            end
        end else if (retire_valid !== 1'b0) begin
            fail_run($sformatf("retire_valid is unknown in cycle %0d", cycle_count));
        end else if (exp_due.size() != 0 && exp_due[0] <= cycle_count) begin
            fail_run($sformatf("Missing retire, expected in cycle %0d", exp_due[0]));
        end
    endtask

    initial begin
        int          issued;
        logic        gap;
        logic [31:0] w;
        logic [31:0] r;
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rng_state   = 32'h77fa_c659;
        cycle_count = 0;
        issued      = 0;
        gap         = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(posedge clock);
            cycle_count++;
            @(negedge clock);
            check_retire_port();
        end
        @(posedge clock);
        cycle_count++;
        reset_n <= 1'b1;
        @(negedge clock);
        check_retire_port();

        while (issued < NUM_INSTR) begin
            @(posedge clock);
            cycle_count++;
            if (gap) begin
                instr_valid <= 1'b0;
                gap = 1'b0;
            end else begin
                w = make_instr();
                instr_valid <= 1'b1;
                instr       <= w;
                model_issue(w, cycle_count + 2);
                issued++;
                r   = next_random();
                gap = (r[31:30] == 2'b00);  // Idle slot after about one in four
            end
            @(negedge clock);
            check_retire_port();
        end

        // Drain the pipeline
        repeat (4) begin
            @(posedge clock);
            cycle_count++;
            instr_valid <= 1'b0;
            @(negedge clock);
            check_retire_port();
        end

        if (exp_due.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("%0d instructions never retired", exp_due.size()));
        end
    end

endmodule
